//--- logic/ddr_cmd_pkg.sv
/* DDR3 command definitions: address and bank widths, RCW opcodes,
   packed sequence word and per-cycle command bus */
package ddr_cmd_pkg;

    localparam int addr_w  = 15; // row / column address bits
    localparam int col_w   = 10; // column address bits
    localparam int bank_w  = 3;
    localparam int pause_w = 10; // pause count in NOP word address field

    localparam logic rd_sel = 1'b1; // half-cycle select used while reading

    // RAS/CAS/WE, positive logic
    typedef enum logic [2:0] {
        RCW_NOP       = 3'd0,
        RCW_READ      = 3'd2,
        RCW_ACTIVATE  = 3'd4,
        RCW_PRECHARGE = 3'd5
    } rcw_e;

    // one word of the sequence memory, 32 bits
    typedef struct packed {
        logic [4:0]        spare;
        logic              done;      // last word of the sequence
        logic              nop_after; // one NOP slot after the command
        logic              buf_rst;   // next page to the page buffer
        logic              buf_wr;    // page buffer write
        logic              dci;       // DCI disable
        logic              sel;       // half-cycle select
        rcw_e              rcw;
        logic [bank_w-1:0] bank;
        logic [addr_w-1:0] addr;      // row, column or pause count
    } cmd_word_t;

    // what goes out to the memory each cycle, all zero is NOP
    typedef struct packed {
        rcw_e              rcw;
        logic [addr_w-1:0] addr;
        logic [bank_w-1:0] bank;
        logic              sel;
        logic              dci;
        logic              buf_wr;
        logic              buf_rst;
    } ddr_cmd_t;

endpackage

//--- logic/seq_ctrl_pkg.sv
/* sequencer control definitions: read request, control states,
   burst count width and sequence memory sizing */
package seq_ctrl_pkg;

    localparam int xfer_w      = 6;  // burst count, 0 means 64
    localparam int seq_aw      = 7;
    localparam int seq_depth   = 1 << seq_aw;
    localparam int seq_max_len = 71; // 64 reads plus 7 fixed words

    localparam logic [2:0] enc_loop_step = 3'd2; // READ step, repeated
    localparam logic [2:0] enc_last_step = 3'd7; // done NOP step

    typedef struct packed {
        logic [ddr_cmd_pkg::bank_w-1:0]  bank;
        logic [ddr_cmd_pkg::addr_w-1:0]  row;
        logic [ddr_cmd_pkg::col_w-4:0]   start_col;      // in 8-bursts
        logic [xfer_w-1:0]               num128;         // bursts of 8
        logic                            skip_next_page; // keep page buffer
    } rd_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ENCODE,
        ST_PLAY
    } seq_state_e;

endpackage

//--- logic/cmd_encoder_linear_rd.sv
/* linear page read encoder: walks a step table and writes
   ACTIVATE, READ burst, PRECHARGE words into the sequence memory */
`timescale 1ns/10ps

module cmd_encoder_linear_rd (
    input  logic                   clk,
    input  logic                   mrst,
    input  logic                   enc_start,
    input  seq_ctrl_pkg::rd_req_t  enc_req,
    output ddr_cmd_pkg::cmd_word_t enc_cmd,
    output logic                   enc_wr,
    output logic                   enc_done
);
    import ddr_cmd_pkg::*;
    import seq_ctrl_pkg::*;

    // word kind held in the step table
    typedef struct packed {
        rcw_e       rcw;
        logic [1:0] pause;     // extra NOP cycles
        logic       nop_after;
        logic       buf_wr;
        logic       dci;
        logic       sel;
        logic       pgnext;    // page buffer reset request
        logic       last;
    } kind_t;

    function automatic kind_t kind_of(input logic [2:0] s);
        kind_t k;
        k = '0;
        case (s)
            3'd0: k.rcw = RCW_ACTIVATE;
            3'd1: k.pause = 2'd1;         // tRCD
            3'd2: begin
                k.rcw       = RCW_READ;
                k.nop_after = 1'b1;       // one burst of 8 every 2 cycles
                k.buf_wr    = 1'b1;
                k.dci       = 1'b1;
                k.sel       = rd_sel;
            end
            3'd3: begin
                k.pause = 2'd1;           // let the last burst drain
                k.dci   = 1'b1;
                k.sel   = rd_sel;
            end
            3'd4: begin
                k.pgnext = 1'b1;
                k.dci    = 1'b1;
                k.sel    = rd_sel;
            end
            3'd5: begin
                k.rcw = RCW_PRECHARGE;
                k.dci = 1'b1;
            end
            3'd6: begin
                k.pause = 2'd2;           // tRP before anything else
                k.dci   = 1'b1;
            end
            default: k.last = 1'b1;
        endcase
        return k;
    endfunction

    logic [2:0]      step;
    logic            run;
    logic            tab_vld; // kind_r holds a word to encode
    kind_t           kind_r;
    logic [xfer_w:0] left;    // reads still to issue
    logic [col_w-4:0] col;
    rd_req_t         req_r;
    cmd_word_t       word;

    always_ff @(posedge clk) begin
        if (mrst) begin
            run     <= 1'b0;
            tab_vld <= 1'b0;
            step    <= '0;
        end else begin
            tab_vld <= enc_start | run;
            if (enc_start)
                run <= 1'b1;
            else if (run && step == enc_last_step)
                run <= 1'b0;
            if (!(enc_start || run))
                step <= '0;
            else if (step != enc_loop_step || left == {{xfer_w{1'b0}}, 1'b1})
                step <= step + 3'd1; // last step wraps to 0
        end
    end

    always_ff @(posedge clk) begin
        kind_r <= kind_of(step); // registered table
        if (enc_start) begin
            req_r <= enc_req;
            col   <= enc_req.start_col;
            left  <= {(enc_req.num128 == '0), enc_req.num128}; // 0 -> 64
        end else begin
            if (tab_vld && kind_r.rcw == RCW_READ)
                col <= col + (col_w - 3)'(1);
            if (run && step == enc_loop_step)
                left <= left - (xfer_w + 1)'(1);
        end
    end

    always_comb begin
        word           = '0;
        word.rcw       = kind_r.rcw;
        word.sel       = kind_r.sel;
        word.dci       = kind_r.dci;
        word.buf_wr    = kind_r.buf_wr;
        word.nop_after = kind_r.nop_after;
        word.done      = kind_r.last;
        word.buf_rst   = kind_r.pgnext & ~req_r.skip_next_page;
        case (kind_r.rcw)
            RCW_READ: begin
                word.addr = {{(addr_w - col_w){1'b0}}, col, 3'b000}; // 8-burst aligned
                word.bank = req_r.bank;
            end
            RCW_NOP: word.addr[pause_w-1:0] = pause_w'(kind_r.pause);
            default: begin
                word.addr = req_r.row; // ACTIVATE and PRECHARGE
                word.bank = req_r.bank;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        enc_cmd <= word;
        if (mrst) begin
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else begin
            enc_wr   <= tab_vld;
            enc_done <= enc_wr & ~tab_vld; // right after the last write
        end
    end

    // a new sequence may not start writing right behind the previous one
    a_no_wr_after_done: assert property (@(posedge clk) disable iff (mrst)
        enc_done |=> !enc_wr);

endmodule

//--- logic/cmd_seq_mem.sv
/* sequence word memory, one write port and one registered read port */
`timescale 1ns/10ps

module cmd_seq_mem (
    input  logic                             clk,
    input  logic                             wr_en,
    input  logic [seq_ctrl_pkg::seq_aw-1:0]  wr_addr,
    input  ddr_cmd_pkg::cmd_word_t           wr_data,
    input  logic [seq_ctrl_pkg::seq_aw-1:0]  rd_addr,
    output ddr_cmd_pkg::cmd_word_t           rd_data
);
    import ddr_cmd_pkg::*;
    import seq_ctrl_pkg::*;

    cmd_word_t mem [seq_depth]; // encoder fills, player drains

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

endmodule

//--- logic/cmd_player.sv
/* sequence player: fetches words in order and expands pauses and
   NOP slots into one DDR command per cycle */
`timescale 1ns/10ps

module cmd_player (
    input  logic                             clk,
    input  logic                             mrst,
    input  logic                             play_start,
    output logic [seq_ctrl_pkg::seq_aw-1:0]  rd_addr,
    input  ddr_cmd_pkg::cmd_word_t           rd_data,
    output ddr_cmd_pkg::ddr_cmd_t            ddr_cmd,
    output logic                             play_done
);
    import ddr_cmd_pkg::*;
    import seq_ctrl_pkg::*;

    logic             run;
    logic             prime;  // first read in flight
    logic             fin;    // done word on the bus
    logic [pause_w:0] cnt;    // filler slots left for current word
    logic [pause_w:0] fill;   // filler slots of word on rd_data
    logic             issue;  // rd_data goes out this cycle
    logic             filler;
    logic             adv;    // next cycle issues, so prefetch
    ddr_cmd_t         slot;

    assign issue  = run & ~prime & (cnt == '0);
    assign filler = run & ~prime & (cnt != '0);

    always_comb begin
        fill = {1'b0, (rd_data.rcw == RCW_NOP) ? rd_data.addr[pause_w-1:0] : '0}
             + (pause_w + 1)'(rd_data.nop_after);
        adv  = prime
             | (issue & ~rd_data.done & (fill == '0))
             | (filler & (cnt == (pause_w + 1)'(1)));
    end

    always_comb begin
        slot         = '0;
        slot.sel     = rd_data.sel;
        slot.dci     = rd_data.dci;
        slot.buf_wr  = rd_data.buf_wr;
        slot.buf_rst = rd_data.buf_rst;
        if (rd_data.rcw != RCW_NOP) begin // NOP address is a pause count
            slot.rcw  = rd_data.rcw;
            slot.addr = rd_data.addr;
            slot.bank = rd_data.bank;
        end
    end

    always_ff @(posedge clk) begin
        if (mrst) begin
            run       <= 1'b0;
            prime     <= 1'b0;
            fin       <= 1'b0;
            play_done <= 1'b0;
            cnt       <= '0;
            rd_addr   <= '0;
            ddr_cmd   <= '0;
        end else begin
            prime     <= play_start;
            fin       <= issue & rd_data.done;
            play_done <= fin;
            ddr_cmd   <= issue ? slot : '0; // zeros on filler slots
            if (play_start) begin
                run     <= 1'b1;
                cnt     <= '0;
                rd_addr <= '0;
            end else begin
                if (issue && rd_data.done)
                    run <= 1'b0;
                if (issue)
                    cnt <= fill;
                else if (filler)
                    cnt <= cnt - (pause_w + 1)'(1);
                if (adv)
                    rd_addr <= rd_addr + seq_aw'(1);
            end
        end
    end

    // the encoder always ends a sequence with a done word
    a_rd_addr_bound: assert property (@(posedge clk) disable iff (mrst)
        rd_addr <= seq_aw'(seq_max_len));

endmodule

//--- logic/seq_ctrl.sv
/* control FSM: accepts a read request, runs the encoder, then the player */
`timescale 1ns/10ps

module seq_ctrl (
    input  logic                             clk,
    input  logic                             mrst,
    input  logic                             req_start,
    input  seq_ctrl_pkg::rd_req_t            req,
    input  logic                             enc_done,
    input  logic                             enc_wr,
    input  logic                             play_done,
    output logic                             enc_start,
    output seq_ctrl_pkg::rd_req_t            enc_req,
    output logic [seq_ctrl_pkg::seq_aw-1:0]  wr_addr,
    output logic                             play_start,
    output logic                             busy,
    output logic                             seq_done
);
    import seq_ctrl_pkg::*;

    seq_state_e state;
    logic       accept;

    assign accept = req_start & (state == ST_IDLE); // starts while busy are dropped
    assign busy   = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (accept)
            enc_req <= req; // held for the whole sequence
    end

    always_ff @(posedge clk) begin
        if (mrst) begin
            state      <= ST_IDLE;
            enc_start  <= 1'b0;
            play_start <= 1'b0;
            seq_done   <= 1'b0;
            wr_addr    <= '0;
        end else begin
            enc_start  <= accept;
            play_start <= 1'b0;
            seq_done   <= play_done;
            if (enc_start)
                wr_addr <= '0;
            else if (enc_wr)
                wr_addr <= wr_addr + seq_aw'(1); // one word per write
            case (state)
                ST_IDLE:
                    if (accept)
                        state <= ST_ENCODE;
                ST_ENCODE:
                    if (enc_done) begin
                        state      <= ST_PLAY;
                        play_start <= 1'b1;
                    end
                ST_PLAY:
                    if (play_done)
                        state <= ST_IDLE; // busy drops with seq_done
                default: state <= ST_IDLE;
            endcase
        end
    end

    // encoder only runs while the FSM waits for it
    a_enc_done_in_encode: assert property (@(posedge clk) disable iff (mrst)
        enc_done |-> state == ST_ENCODE);

endmodule

//--- logic/linear_rd_top.sv
/* linear page read subsystem: controller, encoder, sequence memory, player */
`timescale 1ns/10ps

module linear_rd_top (
    input  logic                  clk,
    input  logic                  mrst,
    input  logic                  req_start,
    input  seq_ctrl_pkg::rd_req_t req,
    output logic                  busy,
    output ddr_cmd_pkg::ddr_cmd_t ddr_cmd,
    output logic                  seq_done
);
    import ddr_cmd_pkg::*;
    import seq_ctrl_pkg::*;

    logic              enc_start;
    rd_req_t           enc_req;
    cmd_word_t         enc_cmd;
    logic              enc_wr;
    logic              enc_done;
    logic [seq_aw-1:0] wr_addr;
    logic [seq_aw-1:0] rd_addr;
    cmd_word_t         rd_data;
    logic              play_start;
    logic              play_done;

    seq_ctrl ctrl_i (
        .clk        (clk),
        .mrst       (mrst),
        .req_start  (req_start),
        .req        (req),
        .enc_done   (enc_done),
        .enc_wr     (enc_wr),
        .play_done  (play_done),
        .enc_start  (enc_start),
        .enc_req    (enc_req),
        .wr_addr    (wr_addr),
        .play_start (play_start),
        .busy       (busy),
        .seq_done   (seq_done)
    );

    cmd_encoder_linear_rd enc_i (
        .clk       (clk),
        .mrst      (mrst),
        .enc_start (enc_start),
        .enc_req   (enc_req),
        .enc_cmd   (enc_cmd),
        .enc_wr    (enc_wr),
        .enc_done  (enc_done)
    );

    cmd_seq_mem mem_i (
        .clk     (clk),
        .wr_en   (enc_wr),
        .wr_addr (wr_addr),
        .wr_data (enc_cmd),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cmd_player player_i (
        .clk        (clk),
        .mrst       (mrst),
        .play_start (play_start),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .ddr_cmd    (ddr_cmd),
        .play_done  (play_done)
    );

endmodule

//--- test/tb_linear_rd.sv
/* testbench for the linear page read subsystem: command stream model,
   bus monitor, compare tasks, directed tests and watchdog */
`timescale 1ns/10ps

module tb_linear_rd;
    import ddr_cmd_pkg::*;
    import seq_ctrl_pkg::*;

    localparam int clk_period = 40;
    localparam int rst_cycles = 16;
    localparam int n_b2b      = 4;  // back-to-back requests
    localparam int slack      = 20; // spare cycles per request

    logic     clk = 1'b0;
    logic     mrst;
    logic     req_start;
    rd_req_t  req;
    logic     busy;
    ddr_cmd_t ddr_cmd;
    logic     seq_done;

    int       seed;
    int       cyc = 0;          // rising edges so far
    int       start_cyc;        // cycle of the last req_start
    logic     rec_on = 1'b0;
    ddr_cmd_t got_cmd[$];       // non-zero bus cycles
    int       got_off[$];       // their offsets from req_start
    int       done_off;
    int       busy_off;
    ddr_cmd_t exp_cmd[$];
    int       exp_off[$];
    rd_req_t  b2b_req[n_b2b];
    int       budget;
    logic     budget_set;

    linear_rd_top dut_i (
        .clk       (clk),
        .mrst      (mrst),
        .req_start (req_start),
        .req       (req),
        .busy      (busy),
        .ddr_cmd   (ddr_cmd),
        .seq_done  (seq_done)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk)
        cyc = cyc + 1;

    // bus monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (req_start) begin // cycle 0 of a new request
            got_cmd.delete();
            got_off.delete();
            start_cyc = cyc;
            done_off  = -1;
            busy_off  = -1;
            rec_on    = 1'b1;
        end
        if (rec_on) begin
            if (ddr_cmd != '0) begin
                got_cmd.push_back(ddr_cmd);
                got_off.push_back(cyc - start_cyc);
            end
            if (busy && busy_off < 0)
                busy_off = cyc - start_cyc;
            if (seq_done) begin
                done_off = cyc - start_cyc;
                rec_on   = 1'b0;
            end
        end
    end

    task automatic check_cmd(input ddr_cmd_t got, input ddr_cmd_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "command mismatch");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    function automatic int burst_count(input rd_req_t r);
        return (r.num128 == '0) ? 64 : int'(r.num128); // 0 means a full page
    endfunction

    // req_start to seq_done: enc_start, write delay, N+7 writes, enc_done,
    // play_start, bus delay, 2N+11 player cycles, seq_done register
    function automatic int seq_cycles(input rd_req_t r);
        return 1 + 2 + (burst_count(r) + 7) + 1 + 3 + (2 * burst_count(r) + 11) + 1;
    endfunction

    // flags are sel, dci, buf_wr, buf_rst
    task automatic add_slot(input int off, input rcw_e rcw, input logic [addr_w-1:0] addr,
                            input logic [bank_w-1:0] bank, input logic [3:0] flags);
        ddr_cmd_t c;
        c      = '0;
        c.rcw  = rcw;
        c.addr = addr;
        c.bank = bank;
        {c.sel, c.dci, c.buf_wr, c.buf_rst} = flags;
        if (c != '0) begin // all-zero slots are NOPs on the bus
            exp_cmd.push_back(c);
            exp_off.push_back(off);
        end
    endtask

    task automatic build_model(input rd_req_t r);
        int               t;
        int               k;
        logic [col_w-4:0] col;
        exp_cmd.delete();
        exp_off.delete();
        t = seq_cycles(r) - 1 - (2 * burst_count(r) + 11); // first bus command
        add_slot(t, RCW_ACTIVATE, r.row, r.bank, 4'b0000);
        t   = t + 3; // ACTIVATE, NOP and one pause
        col = r.start_col;
        for (k = 0; k < burst_count(r); k++) begin
            add_slot(t, RCW_READ, addr_w'({col, 3'b000}), r.bank, 4'b1110);
            col = col + (col_w - 3)'(1); // 8 columns per burst
            t   = t + 2;
        end
        add_slot(t, RCW_NOP, '0, '0, 4'b1100);
        t = t + 2;
        add_slot(t, RCW_NOP, '0, '0, {3'b110, ~r.skip_next_page});
        add_slot(t + 1, RCW_PRECHARGE, r.row, r.bank, 4'b0100);
        add_slot(t + 2, RCW_NOP, '0, '0, 4'b0100); // pause 2, done word is zero
    endtask

    function automatic int count_reads();
        int n;
        n = 0;
        foreach (got_cmd[i])
            if (got_cmd[i].rcw == RCW_READ)
                n++;
        return n;
    endfunction

    function automatic int count_buf_rst();
        int n;
        n = 0;
        foreach (got_cmd[i])
            if (got_cmd[i].buf_rst)
                n++;
        return n;
    endfunction

    // issue one request, wait for seq_done and compare with the model
    task automatic run_request(input rd_req_t r);
        int i;
        build_model(r);
        @(posedge clk);
        #2;
        req       = r;
        req_start = 1'b1;
        @(posedge clk);
        #2;
        req_start = 1'b0;
        do
            @(negedge clk);
        while (!seq_done);
        #1;
        check_bit(busy, 1'b0, "busy in seq_done cycle");
        check_count(got_cmd.size(), exp_cmd.size(), "number of non-zero bus cycles");
        for (i = 0; i < exp_cmd.size(); i++) begin
            check_cmd(got_cmd[i], exp_cmd[i], $sformatf("bus command %0d", i));
            check_count(got_off[i], exp_off[i], $sformatf("cycle of bus command %0d", i));
        end
        check_count(busy_off, 1, "busy rise cycle");
        check_count(done_off, seq_cycles(r), "seq_done cycle");
    endtask

    function automatic rd_req_t make_req(input int bank, input int row, input int col,
                                         input int num, input logic skip);
        rd_req_t r;
        r.bank           = bank_w'(bank);
        r.row            = addr_w'(row);
        r.start_col      = (col_w - 3)'(col);
        r.num128         = xfer_w'(num);
        r.skip_next_page = skip;
        return r;
    endfunction

    task automatic test_after_reset();
        repeat (3) begin
            @(negedge clk);
            check_bit(busy, 1'b0, "busy after reset");
            check_bit(seq_done, 1'b0, "seq_done after reset");
            check_cmd(ddr_cmd, '0, "ddr_cmd after reset");
        end
    endtask

    task automatic test_single_read(input rd_req_t r); // stream and timing
        run_request(r);
        check_count(count_reads(), 4, "READ count");
        check_count(count_buf_rst(), 1, "buf_rst slots");
    endtask

    task automatic test_skip_page(input rd_req_t r);
        run_request(r);
        check_count(count_reads(), 1, "READ count");
        check_count(count_buf_rst(), 0, "buf_rst slots with skip_next_page");
        check_count(done_off - got_off[0], 2 * 1 + 11 + 1, "player length");
    endtask

    task automatic test_full_page(input rd_req_t r);
        run_request(r);
        check_count(count_reads(), 64, "READ count for burst count 0");
    endtask

    task automatic test_back_to_back();
        int i;
        for (i = 0; i < n_b2b; i++)
            run_request(b2b_req[i]); // starts the cycle after seq_done
    endtask

    initial begin
        rd_req_t     r_single;
        rd_req_t     r_skip;
        rd_req_t     r_full;
        logic [31:0] rnd;
        int          i;
        mrst       = 1'b1;
        req_start  = 1'b0;
        req        = '0;
        budget_set = 1'b0;
        seed       = 32'h46b8;
        r_single   = make_req(5, 'h1a2b, 12, 4, 1'b0);
        r_skip     = make_req(2, 'h0777, 101, 1, 1'b1);
        r_full     = make_req(7, 'h7ffe, 0, 0, 1'b0);
        for (i = 0; i < n_b2b; i++) begin
            rnd        = $random(seed);
            b2b_req[i] = make_req(int'(rnd[2:0]), int'(rnd[17:3]), int'(rnd[24:18]),
                                  int'(rnd[30:25]), 1'b0);
            rnd        = $random(seed);
            b2b_req[i].skip_next_page = rnd[0];
        end
        budget = rst_cycles + 3 + 3 * slack + seq_cycles(r_single)
               + seq_cycles(r_skip) + seq_cycles(r_full);
        for (i = 0; i < n_b2b; i++)
            budget = budget + seq_cycles(b2b_req[i]) + slack;
        budget_set = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #2;
        mrst = 1'b0;
        test_after_reset();
        test_single_read(r_single);
        test_skip_page(r_skip);
        test_full_page(r_full);
        test_back_to_back();
        $display(">>> PASS");
        $finish;
    end

    // watchdog
    initial begin
        wait (budget_set);
        repeat (budget) @(posedge clk);
        $display("run hung: tests not finished after %0d cycles", budget);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- compile.f
logic/ddr_cmd_pkg.sv
logic/seq_ctrl_pkg.sv
logic/cmd_encoder_linear_rd.sv
logic/cmd_seq_mem.sv
logic/cmd_player.sv
logic/seq_ctrl.sv
logic/linear_rd_top.sv
test/tb_linear_rd.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_linear_rd
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
